/* rv_pkg.sv */
package rv_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int xlen    = 32;
    localparam int imem_aw = 8;                          // 256 instruction words.
    localparam int dmem_aw = 8;
    localparam int axi_aw  = 12;                         // Register block address width.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcodes and ALU operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_system = 7'b1110011;   // Only ECALL is recognised.

    localparam logic [3:0] alu_add = 4'd0;
    localparam logic [3:0] alu_sub = 4'd1;
    localparam logic [3:0] alu_and = 4'd2;
    localparam logic [3:0] alu_or  = 4'd3;
    localparam logic [3:0] alu_xor = 4'd4;
    localparam logic [3:0] alu_slt = 4'd5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register block map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [11:0] reg_ctrl_addr   = 12'h000;
    localparam logic [11:0] reg_status_addr = 12'h004;
    localparam logic [11:0] reg_pc_addr     = 12'h008;
    localparam logic [11:0] reg_cycles_addr = 12'h00C;
    localparam logic [11:0] regs_base       = 12'h080;   // x0 to x31.
    localparam logic [11:0] imem_base       = 12'h400;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

/* rv_alu.sv */
module rv_alu import rv_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  logic [3:0]      op,
    output logic [xlen-1:0] result,
    output logic            zero
);

    logic lt;

    assign lt = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = a - b;                          // BEQ compares through this.
            end
            alu_and: begin
                result = a & b;
            end
            alu_or: begin
                result = a | b;
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, lt};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

/* rv_decoder.sv */
module rv_decoder import rv_pkg::*; (
    input  logic [xlen-1:0] instr,
    output logic            branch,
    output logic            mem_to_reg,
    output logic            mem_write,
    output logic            alu_src,
    output logic            reg_write,
    output logic            halt,
    output logic [3:0]      alu_op,
    output logic [xlen-1:0] imm
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            funct7_b5;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Immediates
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        branch     = 1'b0;
        mem_to_reg = 1'b0;
        mem_write  = 1'b0;
        alu_src    = 1'b0;
        reg_write  = 1'b0;
        halt       = 1'b0;
        alu_op     = alu_add;
        imm        = '0;
        case (opcode)
            op_rtype: begin
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = funct7_b5 ? alu_sub : alu_add;
                    3'b111:  alu_op = alu_and;
                    3'b110:  alu_op = alu_or;
                    3'b100:  alu_op = alu_xor;
                    3'b010:  alu_op = alu_slt;
                    default: alu_op = alu_add;
                endcase
            end
            op_itype: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                imm       = imm_i;
            end
            op_load: begin
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                mem_to_reg = 1'b1;
                imm        = imm_i;
            end
            op_store: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm       = imm_s;
            end
            op_branch: begin
                branch = 1'b1;
                alu_op = alu_sub;                        // Zero flag means equal.
                imm    = imm_b;
            end
            op_system: begin
                halt = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

/* rv_regfile.sv */
module rv_regfile import rv_pkg::*; (
    input  logic            CLK,
    input  logic            RESET_N,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic [4:0]      dbg_addr,
    input  logic [xlen-1:0] wdata,
    input  logic            we,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2,
    output logic [xlen-1:0] dbg_data
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1   = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2   = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign dbg_data = (dbg_addr == 5'd0) ? '0 : regs[dbg_addr];   // Host view.

    a_x0_zero: assert property (
        @(posedge CLK) disable iff (!RESET_N) regs[0] == '0
    ) else $error("x0 holds a nonzero value");

endmodule

/* rv_mem.sv */
module rv_mem import rv_pkg::*; #(
    parameter int aw = 8
) (
    input  logic            CLK,
    input  logic            we,
    input  logic [aw-1:0]   waddr,
    input  logic [aw-1:0]   raddr,
    input  logic [xlen-1:0] wdata,
    output logic [xlen-1:0] rdata
);

    logic [xlen-1:0] mem [2**aw];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr];                           // Read is combinational.

    a_waddr_known: assert property (
        @(posedge CLK) we |-> !$isunknown(waddr)
    ) else $error("memory write with unknown address");

endmodule

/* rv_core.sv */
module rv_core import rv_pkg::*; (
    input  logic               CLK,
    input  logic               RESET_N,
    input  logic               run,
    input  logic               imem_we,
    input  logic [imem_aw-1:0] imem_waddr,
    input  logic [xlen-1:0]    imem_wdata,
    input  logic [4:0]         dbg_raddr,
    output logic [xlen-1:0]    pc,
    output logic [xlen-1:0]    cycles,
    output logic [xlen-1:0]    dbg_rdata,
    output logic               halted
);

    logic            run_q;
    logic            start;
    logic            active;
    logic [xlen-1:0] instr;
    logic            branch, mem_to_reg, mem_write, alu_src, reg_write, halt;
    logic [3:0]      alu_op;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_data, rs2_data, alu_b, alu_result, load_data, wb_data;
    logic            zero;
    logic [xlen-1:0] pc_plus4, branch_target, next_pc;

    assign start  = run & ~run_q;                        // Rising run restarts from 0.
    assign active = run & ~halted & ~start;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    rv_mem #(.aw(imem_aw)) imem (.CLK(CLK), .we(imem_we), .waddr(imem_waddr),
        .raddr(pc[imem_aw+1:2]), .wdata(imem_wdata), .rdata(instr));

    rv_decoder decoder (.instr(instr), .branch(branch), .mem_to_reg(mem_to_reg),
        .mem_write(mem_write), .alu_src(alu_src), .reg_write(reg_write), .halt(halt),
        .alu_op(alu_op), .imm(imm));

    rv_regfile regfile (.CLK(CLK), .RESET_N(RESET_N), .rs1(instr[19:15]), .rs2(instr[24:20]),
        .rd(instr[11:7]), .dbg_addr(dbg_raddr), .wdata(wb_data), .we(active & reg_write),
        .rdata1(rs1_data), .rdata2(rs2_data), .dbg_data(dbg_rdata));

    assign alu_b = alu_src ? imm : rs2_data;

    rv_alu alu (.a(rs1_data), .b(alu_b), .op(alu_op), .result(alu_result), .zero(zero));

    rv_mem #(.aw(dmem_aw)) dmem (.CLK(CLK), .we(active & mem_write),
        .waddr(alu_result[dmem_aw+1:2]), .raddr(alu_result[dmem_aw+1:2]),
        .wdata(rs2_data), .rdata(load_data));

    assign wb_data       = mem_to_reg ? load_data : alu_result;
    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc + imm;
    assign next_pc       = (branch & zero) ? branch_target : pc_plus4;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            run_q  <= 1'b0;
            pc     <= '0;
            cycles <= '0;
            halted <= 1'b0;
        end else begin
            run_q <= run;
            if (start) begin
                pc     <= '0;
                cycles <= '0;
                halted <= 1'b0;
            end else if (active) begin
                if (halt) begin
                    halted <= 1'b1;                      // PC stays on the ECALL.
                end else begin
                    pc     <= next_pc;
                    cycles <= cycles + 1'b1;
                end
            end
        end
    end

    a_pc_aligned: assert property (
        @(posedge CLK) disable iff (!RESET_N) pc[1:0] == 2'b00
    ) else $error("pc is not word aligned");

endmodule

/* rv_axil_regs.sv */
module rv_axil_regs import rv_pkg::*; (
    input  logic               CLK,
    input  logic               RESET_N,
    input  logic [axi_aw-1:0]  awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  logic [xlen-1:0]    wdata,
    input  logic [3:0]         wstrb,
    input  logic               wvalid,
    output logic               wready,
    output logic [1:0]         bresp,
    output logic               bvalid,
    input  logic               bready,
    input  logic [axi_aw-1:0]  araddr,
    input  logic               arvalid,
    output logic               arready,
    output logic [xlen-1:0]    rdata,
    output logic [1:0]         rresp,
    output logic               rvalid,
    input  logic               rready,
    input  logic               halted,
    input  logic [xlen-1:0]    pc,
    input  logic [xlen-1:0]    cycles,
    input  logic [xlen-1:0]    dbg_rdata,
    output logic               run,
    output logic               imem_we,
    output logic [imem_aw-1:0] imem_waddr,
    output logic [xlen-1:0]    imem_wdata,
    output logic [4:0]         dbg_raddr
);

    logic            accept_q;
    logic            halted_q;
    logic            wr_fire, rd_fire;
    logic            aw_imem, aw_regs, ar_regs;
    logic [1:0]      wr_resp, rd_resp;
    logic [xlen-1:0] rd_word;

    assign awready   = accept_q;
    assign wready    = accept_q;
    assign arready   = ~rvalid;
    assign wr_fire   = accept_q & awvalid & wvalid;
    assign rd_fire   = arvalid & arready;
    assign dbg_raddr = araddr[6:2];                      // Register window index.

    assign aw_imem = awaddr[axi_aw-1:imem_aw+2] == imem_base[axi_aw-1:imem_aw+2];
    assign aw_regs = awaddr[axi_aw-1:7] == regs_base[axi_aw-1:7];
    assign ar_regs = araddr[axi_aw-1:7] == regs_base[axi_aw-1:7];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Response decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        wr_resp = resp_okay;
        if (aw_imem) begin
            if (run) wr_resp = resp_slverr;              // Program is locked while running.
        end else if (!(aw_regs || awaddr == reg_ctrl_addr || awaddr == reg_status_addr ||
                       awaddr == reg_pc_addr || awaddr == reg_cycles_addr)) begin
            wr_resp = resp_slverr;
        end
    end

    always_comb begin
        rd_word = '0;
        rd_resp = resp_okay;
        if (ar_regs) begin
            rd_word = dbg_rdata;
        end else begin
            case (araddr)
                reg_ctrl_addr:   rd_word = {{(xlen-1){1'b0}}, run};
                reg_status_addr: rd_word = {{(xlen-2){1'b0}}, run, halted};
                reg_pc_addr:     rd_word = pc;
                reg_cycles_addr: rd_word = cycles;
                default:         rd_resp = resp_slverr;
            endcase
        end
    end

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            accept_q <= 1'b0;
            halted_q <= 1'b0;
            bvalid   <= 1'b0;
            rvalid   <= 1'b0;
            run      <= 1'b0;
            imem_we  <= 1'b0;
        end else begin
            halted_q <= halted;
            imem_we  <= 1'b0;
            accept_q <= awvalid & wvalid & ~bvalid & ~accept_q;
            if (halted & ~halted_q) run <= 1'b0;         // Core reached ECALL.
            if (wr_fire) begin
                bvalid <= 1'b1;
                if (awaddr == reg_ctrl_addr) run <= wdata[0];
                if (aw_imem & ~run) imem_we <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Byte lanes in wstrb are not decoded; every accepted write stores a full word.
    always_ff @(posedge CLK) begin
        if (wr_fire) begin
            bresp      <= wr_resp;
            imem_waddr <= awaddr[imem_aw+1:2];
            imem_wdata <= wdata;
        end
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

    a_bvalid_hold: assert property (
        @(posedge CLK) disable iff (!RESET_N) bvalid && !bready |=> bvalid
    ) else $error("bvalid dropped before bready");

endmodule

/* rv_soc_top.sv */
module rv_soc_top import rv_pkg::*; (
    input  logic              CLK,
    input  logic              RESET_N,
    input  logic [axi_aw-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [xlen-1:0]   wdata,
    input  logic [3:0]        wstrb,
    input  logic              wvalid,
    output logic              wready,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [axi_aw-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [xlen-1:0]   rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready
);

    logic               run, imem_we, halted;
    logic [imem_aw-1:0] imem_waddr;
    logic [xlen-1:0]    imem_wdata, pc, cycles, dbg_rdata;
    logic [4:0]         dbg_raddr;

    rv_axil_regs regs (.CLK(CLK), .RESET_N(RESET_N), .awaddr(awaddr), .awvalid(awvalid),
        .awready(awready), .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready), .araddr(araddr), .arvalid(arvalid),
        .arready(arready), .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .halted(halted), .pc(pc), .cycles(cycles), .dbg_rdata(dbg_rdata), .run(run),
        .imem_we(imem_we), .imem_waddr(imem_waddr), .imem_wdata(imem_wdata),
        .dbg_raddr(dbg_raddr));

    rv_core core (.CLK(CLK), .RESET_N(RESET_N), .run(run), .imem_we(imem_we),
        .imem_waddr(imem_waddr), .imem_wdata(imem_wdata), .dbg_raddr(dbg_raddr),
        .pc(pc), .cycles(cycles), .dbg_rdata(dbg_rdata), .halted(halted));

endmodule

/* tb_rv_soc.sv */
module tb_rv_soc import rv_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int wait_limit = 1000;

    logic              CLK;
    logic              RESET_N;
    logic [axi_aw-1:0] awaddr, araddr;
    logic              awvalid, awready, wvalid, wready, bvalid, bready;
    logic              arvalid, arready, rvalid, rready;
    logic [xlen-1:0]   wdata, rdata;
    logic [3:0]        wstrb;
    logic [1:0]        bresp, rresp;

    int              errors;
    int              checks;
    int              tests;
    int              test_err_start;
    int              fd, n, c;
    string           kind;
    logic [31:0]     a, b;
    logic [31:0]     prog_addr[$], prog_word[$], reg_idx[$], reg_val[$];
    logic [31:0]     halt_pc, halt_cycles, busy_resp, unmapped_resp;
    logic [31:0]     rd;
    logic [1:0]      resp;

    rv_soc_top UUT (.CLK(CLK), .RESET_N(RESET_N), .awaddr(awaddr), .awvalid(awvalid),
        .awready(awready), .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready), .araddr(araddr), .arvalid(arvalid),
        .arready(arready), .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready));

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s.", what);
        $display("Checks failed");
        $finish;
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic begin_test();
        test_err_start = errors;
        tests++;
    endtask

    task automatic end_test(input string name);
        $display("test %-24s %s", name, (errors == test_err_start) ? "ok" : "FAILED");
    endtask

    // A nonzero hold keeps bready low for that many cycles of bvalid.
    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data, input int hold,
                             output logic [1:0] wr_resp);
        int cnt;
        int held;
        cnt = 0;
        held = 0;
        @(posedge CLK);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= (hold == 0);
        do begin
            @(posedge CLK);
            cnt++;
            if (cnt > wait_limit) abort_on_timeout("the write address handshake");
        end while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        cnt = 0;
        forever begin
            @(posedge CLK);
            cnt++;
            if (cnt > wait_limit) abort_on_timeout("the write response");
            if (bvalid && bready) break;
            if (held > 0) check("bvalid held", 1, bvalid);
            if (bvalid) begin
                held++;
                if (held >= hold) bready <= 1'b1;
            end
        end
        wr_resp = bresp;
        bready <= 1'b0;
    endtask

    // A nonzero hold keeps rready low and checks that rvalid and rdata stay put.
    task automatic axi_read(input logic [11:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] rd_resp);
        int cnt;
        int held;
        logic [31:0] first;
        cnt = 0;
        held = 0;
        first = '0;
        @(posedge CLK);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= (hold == 0);
        do begin
            @(posedge CLK);
            cnt++;
            if (cnt > wait_limit) abort_on_timeout("the read address handshake");
        end while (!arready);
        arvalid <= 1'b0;
        cnt = 0;
        forever begin
            @(posedge CLK);
            cnt++;
            if (cnt > wait_limit) abort_on_timeout("the read data");
            if (rvalid && rready) break;
            if (held > 0) check("rvalid held", 1, rvalid);
            if (rvalid) begin
                if (held == 0) first = rdata;
                check("rdata held", first, rdata);
                held++;
                if (held >= hold) rready <= 1'b1;
            end
        end
        data = rdata;
        rd_resp = rresp;
        rready <= 1'b0;
    endtask

    task automatic wait_for_halt();
        logic [31:0] st;
        logic [1:0]  r;
        int polls;
        polls = 0;
        st = '0;
        while (st[0] !== 1'b1) begin
            polls++;
            if (polls > wait_limit / 5) abort_on_timeout("the core to halt");
            axi_read(reg_status_addr, 0, st, r);
        end
    endtask

    task automatic check_results(input string tag);
        logic [31:0] v;
        logic [1:0]  r;
        for (int i = 0; i < reg_idx.size(); i++) begin
            axi_read(regs_base + 12'(reg_idx[i] * 4), (i == 3) ? 4 : 0, v, r);
            check($sformatf("%s x%0d", tag, reg_idx[i]), reg_val[i], v);
            check($sformatf("%s x%0d resp", tag, reg_idx[i]), resp_okay, r);
        end
        axi_read(reg_pc_addr, 0, v, r);
        check({tag, " pc"}, halt_pc, v);
        axi_read(reg_cycles_addr, 0, v, r);
        check({tag, " cycles"}, halt_cycles, v);
        axi_read(reg_status_addr, 0, v, r);
        check({tag, " status"}, 32'h1, v);                 // Halted, run cleared.
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        RESET_N = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hF;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        errors  = 0;
        checks  = 0;
        tests   = 0;

        fd = $fopen("rv_golden.txt", "r");
        if (fd == 0) begin
            $display("The golden file could not be opened.");
            $display("Checks failed");
            $finish;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, " %s", kind);
            if (n != 1) break;
            if (kind == "W") begin
                n = $fscanf(fd, " %h %h", a, b);
                prog_addr.push_back(a);
                prog_word.push_back(b);
            end else if (kind == "R") begin
                n = $fscanf(fd, " %h %h", a, b);
                reg_idx.push_back(a);
                reg_val.push_back(b);
            end else if (kind == "H") begin
                n = $fscanf(fd, " %h %h", halt_pc, halt_cycles);
            end else if (kind == "E") begin
                n = $fscanf(fd, " %h", busy_resp);
            end else if (kind == "U") begin
                n = $fscanf(fd, " %h", unmapped_resp);
            end else begin
                do c = $fgetc(fd); while (c != "\n" && c != -1);   // Comment line.
            end
        end
        $fclose(fd);

        repeat (4) @(posedge CLK);
        RESET_N <= 1'b1;

        begin_test();
        axi_read(reg_status_addr, 0, rd, resp);
        check("reset status", 0, rd);
        check("reset status resp", resp_okay, resp);
        axi_read(reg_pc_addr, 0, rd, resp);
        check("reset pc", 0, rd);
        check("reset pc resp", resp_okay, resp);
        axi_read(reg_cycles_addr, 0, rd, resp);
        check("reset cycles", 0, rd);
        check("reset cycles resp", resp_okay, resp);
        end_test("reset values");

        begin_test();
        for (int i = 0; i < prog_addr.size(); i++) begin
            axi_write(imem_base + 12'(prog_addr[i]), prog_word[i], 0, resp);
            check($sformatf("load %h resp", prog_addr[i]), resp_okay, resp);
        end
        axi_write(reg_ctrl_addr, 32'h1, 0, resp);
        check("start resp", resp_okay, resp);
        end_test("load and start");

        begin_test();
        axi_write(imem_base + 12'h044, 32'h0000_0013, 0, resp);
        check("imem write while running", busy_resp, resp);
        end_test("imem lock");

        begin_test();
        wait_for_halt();
        check_results("run1");
        end_test("first run");

        begin_test();
        axi_read(12'h010, 0, rd, resp);
        check("unmapped data", 0, rd);
        check("unmapped resp", unmapped_resp, resp);
        end_test("unmapped read");

        begin_test();
        axi_write(reg_ctrl_addr, 32'h1, 4, resp);          // Response waits on bready.
        check("restart resp", resp_okay, resp);
        axi_read(reg_status_addr, 0, rd, resp);
        check("restart status", 32'h2, rd);                // Running again, not halted.
        wait_for_halt();
        check_results("run2");
        end_test("restart");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* flist.f */
rv_pkg.sv
rv_alu.sv
rv_decoder.sv
rv_regfile.sv
rv_mem.sv
rv_core.sv
rv_axil_regs.sv
rv_soc_top.sv
tb_rv_soc.sv

/* Bender.yml */
package:
  name: rv_soc

sources:
  - rv_pkg.sv
  - rv_alu.sv
  - rv_decoder.sv
  - rv_regfile.sv
  - rv_mem.sv
  - rv_core.sv
  - rv_axil_regs.sv
  - rv_soc_top.sv
  - target: simulation
    files:
      - tb_rv_soc.sv

/* rv_golden.txt */
# W imem_byte_addr word | R reg value | H halt_pc cycles
# E resp_imem_write_while_running | U resp_unmapped_read
W 000 00500093
W 004 00300113
W 008 002081B3
W 00C 40208233
W 010 0020F2B3
W 014 0020E333
W 018 0020C3B3
W 01C 00112433
W 020 00302423
W 024 00802483
W 028 00900013
W 02C 00000513
W 030 00150513
W 034 00250463
W 038 FE000CE3
W 03C 00108463
W 040 06300613
W 044 02A00593
W 048 00000073
R 00 00000000
R 01 00000005
R 02 00000003
R 03 00000008
R 04 00000002
R 05 00000001
R 06 00000007
R 07 00000006
R 08 00000001
R 09 00000008
R 0A 00000003
R 0B 0000002A
R 0C 00000000
H 00000048 00000016
E 2
U 2
